// ==== common/cpu_bus_pkg.sv ====
package cpu_bus_pkg;

  typedef logic [15:0] word_t;  // data or instruction word
  typedef logic [15:0] addr_t;  // word address

  // one memory request per cycle with read and write side by side
  typedef struct packed {
    logic  write_enabled;
    addr_t write_address;
    word_t write_value;
    addr_t read_address;  // data comes back on the next cycle
  } mem_req_t;

endpackage

// ==== common/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

  import cpu_bus_pkg::*;

  // upper byte of the first instruction word
  typedef enum logic [7:0] {
    op_jmp       = 8'd1,   // absolute target in word 2
    op_jmp_plus  = 8'd5,   // forward by word 2 instructions
    op_jmp_minus = 8'd7,   // backward by word 2 instructions
    op_ram2reg   = 8'd9,
    op_reg2ram   = 8'd14,
    op_num2reg   = 8'd18,
    op_reg_plus  = 8'd19,
    op_reg_minus = 8'd20,
    op_reg_mul   = 8'd21,
    op_reg_div   = 8'd22
  } opcode_t;

  typedef enum logic [2:0] {
    err_none           = 3'd0,
    err_wrong_address  = 3'd1,
    err_divide_by_zero = 3'd2,
    err_wrong_reg_num  = 3'd3
  } error_code_t;

  typedef enum logic [1:0] {
    alu_add,
    alu_sub,
    alu_mul,
    alu_div
  } alu_op_t;

  typedef logic [4:0] reg_idx_t;

  localparam int reg_count = 32;

  typedef struct packed {
    opcode_t  opcode;
    logic [7:0] high_byte;    // low byte of word 1
    reg_idx_t reg_first;
    logic [5:0] reg_last;     // first register plus count field
    logic     reg_range_bad;  // range runs past the last register
    word_t    operand;        // word 2
  } instr_t;

  function automatic alu_op_t alu_op_of(opcode_t op);
    case (op)
      op_reg_minus: return alu_sub;
      op_reg_mul:   return alu_mul;
      op_reg_div:   return alu_div;
      default:      return alu_add;
    endcase
  endfunction

endpackage

// ==== logic/register_file.sv ====
`timescale 1ns/1ps

module register_file
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rd_idx_a,
  input  reg_idx_t rd_idx_b,
  output word_t    rd_value_a,
  output word_t    rd_value_b,
  input  logic     wr_en,
  input  reg_idx_t wr_idx,
  input  word_t    wr_value
);

  word_t regs [reg_count];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_value;
    end
  end

  assign rd_value_a = regs[rd_idx_a];  // no read delay
  assign rd_value_b = regs[rd_idx_b];

endmodule

// ==== logic/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;
(
  input  logic    clk,
  input  alu_op_t op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result
);

  logic [31:0] product;

  assign product = a * b;

  always_ff @(posedge clk) begin
    case (op)
      alu_add: result <= a + b;  // wraps modulo 2^16
      alu_sub: result <= a - b;
      alu_mul: result <= product[15:0];  // low half only
      alu_div: result <= a / b;  // unsigned, truncating
      default: result <= a;
    endcase
  end

  // control catches a zero divisor before it reaches this unit
  no_div_by_zero : assert property (@(posedge clk) op == alu_div |-> b != '0)
    else $error("divide issued with zero divisor");

endmodule

// ==== core/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  word_t  read_value,
  input  logic   load_word1,
  input  logic   load_word2,
  output instr_t instr
);

  word_t      word1_q;
  word_t      word2_q;
  logic [5:0] reg_last;

  always_ff @(posedge clk) begin
    if (reset) begin
      word1_q <= '0;
      word2_q <= '0;
    end else begin
      if (load_word1) word1_q <= read_value;
      if (load_word2) word2_q <= read_value;
    end
  end

  // count field holds how many registers minus one
  assign reg_last = {1'b0, word1_q[4:0]} + {3'b000, word1_q[7:5]};

  always_comb begin
    instr.opcode        = opcode_t'(word1_q[15:8]);
    instr.high_byte     = word1_q[7:0];
    instr.reg_first     = word1_q[4:0];
    instr.reg_last      = reg_last;
    instr.reg_range_bad = reg_last[5];  // 32 or above
    instr.operand       = word2_q;
  end

endmodule

// ==== core/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;
#(
  parameter addr_t program_start = addr_t'(46),
  parameter addr_t program_last  = addr_t'(127)
) (
  input  logic        clk,
  input  logic        reset,
  input  word_t       read_value,
  input  instr_t      instr,
  output logic        load_word1,
  output logic        load_word2,
  output mem_req_t    mem_req,
  output reg_idx_t    rd_idx_a,
  output reg_idx_t    rd_idx_b,
  input  word_t       rd_value_a,
  input  word_t       rd_value_b,
  output logic        wr_en,
  output reg_idx_t    wr_idx,
  output word_t       wr_value,
  output alu_op_t     alu_op,
  output word_t       alu_a,
  output word_t       alu_b,
  input  word_t       alu_result,
  output logic        halted,
  output error_code_t error_code
);

  typedef enum logic [3:0] {
    st_start,      // present pc once after reset
    st_fetch1,
    st_fetch2,
    st_exec,
    st_set,        // num2reg write loop
    st_alu,
    st_ram_read,
    st_ram_write,
    st_halt
  } stage_t;

  stage_t   stage;
  addr_t    pc;        // start of the current instruction until exec
  reg_idx_t cnt;       // register being moved or issued
  addr_t    mem_addr;  // running address of a block move
  reg_idx_t wr_idx_q;  // register of the result leaving the ALU
  logic     result_valid;
  logic     issue_done;
  logic     last;

  error_code_t exec_err;
  stage_t      exec_stage;
  addr_t       exec_pc;
  addr_t       exec_addr;
  addr_t       plus_target;
  logic [17:0] minus_diff;
  logic        minus_bad;

  assign last        = ({1'b0, cnt} == instr.reg_last);
  assign plus_target = pc + {instr.operand[14:0], 1'b0};
  assign minus_diff  = {2'b00, pc} - {1'b0, instr.operand, 1'b0};
  assign minus_bad   = minus_diff[17] || (minus_diff[15:0] < program_start);  // borrow or too low

  // decision taken in the execute cycle
  always_comb begin
    exec_err   = err_none;
    exec_stage = st_fetch1;
    exec_pc    = pc + 16'd2;
    exec_addr  = pc + 16'd2;
    case (instr.opcode)
      op_jmp: begin
        exec_pc   = instr.operand;
        exec_addr = instr.operand;
        if (instr.high_byte != 8'd0 || instr.operand[0] || instr.operand < program_start) begin
          exec_err = err_wrong_address;
        end
      end
      op_jmp_plus: begin
        exec_pc   = plus_target;
        exec_addr = plus_target;
      end
      op_jmp_minus: begin
        exec_pc   = minus_diff[15:0];
        exec_addr = minus_diff[15:0];
        if (minus_bad) exec_err = err_wrong_address;
      end
      op_num2reg: exec_stage = st_set;
      op_reg_plus, op_reg_minus, op_reg_mul: exec_stage = st_alu;
      op_reg_div: begin
        exec_stage = st_alu;
        if (instr.operand == '0) exec_err = err_divide_by_zero;
      end
      op_ram2reg: begin
        exec_stage = st_ram_read;
        exec_addr  = instr.operand;  // first word arrives in st_ram_read
        if (instr.operand < program_start) exec_err = err_wrong_address;
      end
      op_reg2ram: begin
        exec_stage = st_ram_write;
        if (instr.operand < program_start) exec_err = err_wrong_address;
      end
      default: ;  // unknown opcode is skipped
    endcase
    // only register-range instructions pick a stage other than st_fetch1
    if (exec_stage != st_fetch1 && instr.reg_range_bad) exec_err = err_wrong_reg_num;
    if (exec_err != err_none) exec_stage = st_halt;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stage        <= st_start;
      pc           <= program_start;
      cnt          <= '0;
      error_code   <= err_none;
      result_valid <= 1'b0;
      issue_done   <= 1'b0;
    end else begin
      case (stage)
        st_start:  stage <= st_fetch1;
        st_fetch1: stage <= (pc > program_last) ? st_halt : st_fetch2;
        st_fetch2: stage <= st_exec;
        st_exec: begin
          stage        <= exec_stage;
          pc           <= exec_pc;
          error_code   <= exec_err;
          cnt          <= instr.reg_first;
          mem_addr     <= instr.operand;
          result_valid <= 1'b0;
          issue_done   <= 1'b0;
        end
        st_set, st_ram_read, st_ram_write: begin
          if (last) begin
            stage <= st_fetch1;
          end else begin
            cnt      <= cnt + 5'd1;
            mem_addr <= mem_addr + 16'd1;
          end
        end
        st_alu: begin
          result_valid <= !issue_done;
          if (!issue_done) begin
            wr_idx_q <= cnt;
            if (last) issue_done <= 1'b1;
            else cnt <= cnt + 5'd1;
          end else begin
            stage <= st_fetch1;  // last result written this cycle
          end
        end
        st_halt: ;
        default: stage <= st_halt;
      endcase
    end
  end

  always_comb begin
    load_word1            = 1'b0;
    load_word2            = 1'b0;
    rd_idx_a              = cnt;  // store path
    rd_idx_b              = cnt;  // ALU operand path
    wr_en                 = 1'b0;
    wr_idx                = cnt;
    wr_value              = instr.operand;
    alu_op                = alu_add;
    alu_a                 = rd_value_b;
    alu_b                 = instr.operand;
    mem_req.write_enabled = 1'b0;
    mem_req.write_address = mem_addr;
    mem_req.write_value   = rd_value_a;
    mem_req.read_address  = pc;  // next fetch after a loop ends
    case (stage)
      st_fetch1: begin
        load_word1           = (pc <= program_last);
        mem_req.read_address = pc + 16'd1;
      end
      st_fetch2: load_word2 = 1'b1;
      st_exec:   mem_req.read_address = exec_addr;
      st_set:    wr_en = 1'b1;
      st_ram_read: begin
        wr_en    = 1'b1;
        wr_value = read_value;
        if (!last) mem_req.read_address = mem_addr + 16'd1;
      end
      st_ram_write: mem_req.write_enabled = 1'b1;
      st_alu: begin
        wr_en    = result_valid;
        wr_idx   = wr_idx_q;
        wr_value = alu_result;
        if (!issue_done) alu_op = alu_op_of(instr.opcode);
      end
      default: ;
    endcase
  end

  assign halted = (stage == st_halt);

  // once halted the core stays halted and never writes memory again
  halt_is_final : assert property (@(posedge clk) disable iff (reset)
    halted |=> halted && !mem_req.write_enabled)
    else $error("memory write or restart after halt");

endmodule

// ==== core/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;
#(
  parameter addr_t program_start = addr_t'(46),
  parameter addr_t program_last  = addr_t'(127)
) (
  input  logic        clk,
  input  logic        reset,
  output mem_req_t    mem_req,
  input  word_t       read_value,
  output logic        halted,
  output error_code_t error_code
);

  instr_t   instr;
  logic     load_word1;
  logic     load_word2;
  reg_idx_t rd_idx_a;
  reg_idx_t rd_idx_b;
  word_t    rd_value_a;
  word_t    rd_value_b;
  logic     wr_en;
  reg_idx_t wr_idx;
  word_t    wr_value;
  alu_op_t  alu_op;
  word_t    alu_a;
  word_t    alu_b;
  word_t    alu_result;

  cpu_control #(
    .program_start(program_start),
    .program_last (program_last)
  ) u_control (
    .clk       (clk),
    .reset     (reset),
    .read_value(read_value),
    .instr     (instr),
    .load_word1(load_word1),
    .load_word2(load_word2),
    .mem_req   (mem_req),
    .rd_idx_a  (rd_idx_a),
    .rd_idx_b  (rd_idx_b),
    .rd_value_a(rd_value_a),
    .rd_value_b(rd_value_b),
    .wr_en     (wr_en),
    .wr_idx    (wr_idx),
    .wr_value  (wr_value),
    .alu_op    (alu_op),
    .alu_a     (alu_a),
    .alu_b     (alu_b),
    .alu_result(alu_result),
    .halted    (halted),
    .error_code(error_code)
  );

  instr_decoder u_decoder (
    .clk       (clk),
    .reset     (reset),
    .read_value(read_value),
    .load_word1(load_word1),
    .load_word2(load_word2),
    .instr     (instr)
  );

  register_file u_regs (
    .clk       (clk),
    .reset     (reset),
    .rd_idx_a  (rd_idx_a),
    .rd_idx_b  (rd_idx_b),
    .rd_value_a(rd_value_a),
    .rd_value_b(rd_value_b),
    .wr_en     (wr_en),
    .wr_idx    (wr_idx),
    .wr_value  (wr_value)
  );

  alu_unit u_alu (
    .clk   (clk),
    .op    (alu_op),
    .a     (alu_a),
    .b     (alu_b),
    .result(alu_result)
  );

endmodule

// ==== tb/ram_model.sv ====
`timescale 1ns/1ps

module ram_model
  import cpu_bus_pkg::*;
(
  input  logic     clk,
  input  mem_req_t mem_req,
  output word_t    read_value
);

  localparam int depth = 256;

  word_t mem [depth];  // loaded and inspected by the testbench

  // write and read share one edge and read data shows up a cycle later
  always @(posedge clk) begin
    if (mem_req.write_enabled) begin
      mem[mem_req.write_address[7:0]] <= mem_req.write_value;
    end
    read_value <= mem[mem_req.read_address[7:0]];  // upper address bits are ignored
  end

endmodule

// ==== tb/cpu_core_tb.sv ====
`timescale 1ns/1ps

module cpu_core_tb
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;
();

  localparam int    clk_period_ns = 100;
  localparam int    num_rows      = 10;
  localparam int    row_cycles    = 3000;  // cycle budget per row for the watchdog
  localparam addr_t program_base  = 46;

  typedef struct packed {
    addr_t addr;
    word_t value;
  } mem_word_t;

  logic        clk   = 1'b0;
  logic        reset = 1'b1;
  mem_req_t    mem_req;
  word_t       read_value;
  logic        halted;
  error_code_t error_code;

  // stimulus table with one entry per row
  string       names     [num_rows];
  error_code_t exp_err   [num_rows];
  word_t       prog      [num_rows][16];
  mem_word_t   presets   [num_rows][4];
  mem_word_t   checks    [num_rows][4];
  int          prog_len  [num_rows];
  int          preset_len[num_rows];
  int          check_len [num_rows];
  int          cur = -1;  // row being filled

  logic [31:0] lfsr = 32'he3afe9b1;

  cpu_core u_dut (
    .clk       (clk),
    .reset     (reset),
    .mem_req   (mem_req),
    .read_value(read_value),
    .halted    (halted),
    .error_code(error_code)
  );

  ram_model u_ram (
    .clk       (clk),
    .mem_req   (mem_req),
    .read_value(read_value)
  );

  always #(clk_period_ns / 2) clk = ~clk;

  function automatic logic [31:0] lfsr_next(logic [31:0] state);
    return state[0] ? (state >> 1) ^ 32'h80200003 : state >> 1;  // taps 32, 22, 2, 1
  endfunction

  function automatic word_t random_word();
    word_t w;
    w = '0;
    for (int i = 0; i < 16; i++) begin
      lfsr = lfsr_next(lfsr);
      w    = {w[14:0], lfsr[0]};
    end
    return w;
  endfunction

  task automatic start_row(string name, error_code_t err);
    cur          = cur + 1;
    names[cur]   = name;
    exp_err[cur] = err;
  endtask

  // word 1 is opcode, count minus one, first register
  task automatic add_instr(opcode_t op, int count, int first, word_t operand);
    prog[cur][prog_len[cur]]     = {op, count[2:0], first[4:0]};
    prog[cur][prog_len[cur] + 1] = operand;
    prog_len[cur]                = prog_len[cur] + 2;
  endtask

  task automatic add_preset(addr_t addr, word_t value);
    presets[cur][preset_len[cur]] = '{addr, value};
    preset_len[cur]               = preset_len[cur] + 1;
  endtask

  task automatic add_check(addr_t addr, word_t value);
    checks[cur][check_len[cur]] = '{addr, value};
    check_len[cur]              = check_len[cur] + 1;
  endtask

  task automatic build_table();
    word_t x;
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    x = random_word();
    a = random_word();
    b = random_word();
    c = random_word();
    d = random_word() | 16'h0001;  // divisor kept nonzero
    start_row("num2reg_store", err_none);
    add_instr(op_num2reg, 3, 2, 16'h1234);
    add_instr(op_reg2ram, 3, 2, 16'd200);
    for (int k = 0; k < 4; k++) begin
      add_check(addr_t'(200 + k), 16'h1234);
    end
    start_row("arithmetic", err_none);
    add_instr(op_num2reg, 3, 0, x);
    add_instr(op_reg_plus, 1, 0, a);  // r0 and r1 back to back in the ALU
    add_instr(op_reg_minus, 0, 1, b);
    add_instr(op_reg_mul, 0, 2, c);
    add_instr(op_reg_div, 0, 3, d);
    add_instr(op_reg2ram, 3, 0, 16'd210);
    add_check(16'd210, word_t'(x + a));
    add_check(16'd211, word_t'(x + a - b));
    add_check(16'd212, word_t'(x * c));
    add_check(16'd213, word_t'(x / d));
    start_row("ram_copy", err_none);
    add_preset(16'd150, 16'ha5a5);
    add_preset(16'd151, 16'h0f0f);
    add_preset(16'd152, 16'h1357);
    add_instr(op_ram2reg, 2, 5, 16'd150);
    add_instr(op_reg2ram, 2, 5, 16'd220);
    add_check(16'd220, 16'ha5a5);
    add_check(16'd221, 16'h0f0f);
    add_check(16'd222, 16'h1357);
    start_row("jumps", err_none);
    add_instr(op_num2reg, 0, 1, 16'h00c3);  // at 46
    add_instr(op_jmp, 0, 0, 16'd54);
    add_instr(op_reg2ram, 0, 1, 16'd230);
    add_instr(op_reg2ram, 0, 1, 16'd231);
    add_instr(op_reg2ram, 0, 1, 16'd232);   // at 54
    add_instr(op_jmp_plus, 0, 0, 16'd2);    // 56 forward to 60
    add_instr(op_reg2ram, 0, 1, 16'd233);
    add_instr(op_reg2ram, 0, 1, 16'd234);
    add_check(16'd230, 16'h0000);
    add_check(16'd232, 16'h00c3);
    add_check(16'd233, 16'h0000);
    add_check(16'd234, 16'h00c3);
    start_row("divide_by_zero", err_divide_by_zero);
    add_instr(op_num2reg, 0, 0, 16'd5);
    add_instr(op_reg_div, 0, 0, 16'd0);
    add_instr(op_reg2ram, 0, 0, 16'd240);
    add_check(16'd240, 16'h0000);
    start_row("reg_range", err_wrong_reg_num);
    add_instr(op_num2reg, 0, 0, 16'h7777);
    add_instr(op_num2reg, 7, 30, 16'd1);  // last register would be 37
    add_instr(op_reg2ram, 0, 0, 16'd241);
    add_check(16'd241, 16'h0000);
    start_row("low_address", err_wrong_address);
    add_instr(op_num2reg, 0, 0, 16'h7777);
    add_instr(op_ram2reg, 0, 1, 16'd40);  // r0 keeps its nonzero value
    add_instr(op_reg2ram, 0, 0, 16'd242);
    add_check(16'd242, 16'h0000);
    start_row("odd_jump", err_wrong_address);
    add_instr(op_num2reg, 0, 0, 16'h7777);
    add_instr(op_jmp, 0, 0, 16'd51);
    add_instr(op_reg2ram, 0, 0, 16'd243);
    add_check(16'd243, 16'h0000);
    start_row("jump_minus_low", err_wrong_address);
    add_instr(op_num2reg, 0, 0, 16'h7777);
    add_instr(op_jmp_minus, 0, 0, 16'd2);  // 48 back to 44
    add_instr(op_reg2ram, 0, 0, 16'd244);
    add_check(16'd244, 16'h0000);
    start_row("empty_tail", err_none);
    add_instr(op_num2reg, 0, 4, 16'hbeef);
    add_instr(op_reg2ram, 0, 4, 16'd250);
    add_check(16'd250, 16'hbeef);
  endtask

  task automatic check_word(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_error(string name, error_code_t expected, error_code_t actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected error %0d, actual error %0d", name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic run_row(int r);
    mem_word_t entry;
    @(posedge clk);
    #1;
    reset = 1'b1;
    for (int i = 0; i < u_ram.depth; i++) begin
      u_ram.mem[i] = '0;  // empty words decode as skipped opcodes
    end
    for (int i = 0; i < prog_len[r]; i++) begin
      u_ram.mem[program_base + i] = prog[r][i];
    end
    for (int i = 0; i < preset_len[r]; i++) begin
      u_ram.mem[presets[r][i].addr[7:0]] = presets[r][i].value;
    end
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    do begin
      @(posedge clk);
      #1;
    end while (!halted);
    check_error(names[r], exp_err[r], error_code);
    for (int k = 0; k < check_len[r]; k++) begin
      entry = checks[r][k];
      check_word($sformatf("%s @%0d", names[r], entry.addr), entry.value,
                 u_ram.mem[entry.addr[7:0]]);
    end
  endtask

  initial begin
    build_table();
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial begin
    #(num_rows * row_cycles * clk_period_ns);
    $display("core never halted within %0d cycles of a test", row_cycles);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog timeout");
  end

endmodule

// ==== sources.f ====
common/cpu_bus_pkg.sv
common/cpu_isa_pkg.sv
logic/register_file.sv
logic/alu_unit.sv
core/instr_decoder.sv
core/cpu_control.sv
core/cpu_core.sv
tb/ram_model.sv
tb/cpu_core_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - common/cpu_bus_pkg.sv
  - common/cpu_isa_pkg.sv
  - logic/register_file.sv
  - logic/alu_unit.sv
  - core/instr_decoder.sv
  - core/cpu_control.sv
  - core/cpu_core.sv
  - target: test
    files:
      - tb/ram_model.sv
      - tb/cpu_core_tb.sv
